// File: hdl/cachePkg.sv
// Shared sizes, operation and state enums, and request structs for the cache RTL and testbench
package cachePkg;

  //////////////////////////////
  // Sizes
  localparam int ADR_BITS       = 16;   // Physical byte address
  localparam int WORD_LEN       = 32;   // One processor word
  localparam int LINE_LEN       = 128;  // One cache line, 4 words
  localparam int BEATS_PER_LINE = LINE_LEN / WORD_LEN;
  localparam int LOG_BPL        = 2;    // Beat index width

  //////////////////////////////
  // Enums

  // Processor operation, [1] read and [0] write like the line command
  typedef enum logic [1:0] {
    RW_IDLE  = 2'b00,
    RW_WRITE = 2'b01,
    RW_READ  = 2'b10
  } cacheRwE;

  // Control states of the cache FSM
  typedef enum logic [2:0] {
    STATE_READY,            // Hits complete here
    STATE_WRITEBACK,        // Dirty victim goes out first
    STATE_FETCH,            // Line fill from memory
    STATE_WRITE_LINE,       // Install fetched line
    STATE_FLUSH_CHECK,      // Look at one way of one set
    STATE_FLUSH_WRITEBACK,  // Write that line back
    STATE_FLUSH_NEXT        // Step way and set counters
  } cacheStateE;

  //////////////////////////////
  // Structs

  typedef struct packed {
    cacheRwE               rw;
    logic [ADR_BITS-1:0]   adr;        // Byte address
    logic [3:0]            byteMask;   // Store byte enables
    logic [WORD_LEN-1:0]   writeData;
  } cpuReqT;

  typedef struct packed {
    logic                  read;
    logic                  write;
    logic [ADR_BITS-1:0]   adr;        // Word-aligned
    logic [WORD_LEN-1:0]   writeData;
  } busReqT;

  // Line command from cache to bus engine
  typedef struct packed {
    logic [1:0]            rw;         // [1] fetch, [0] writeback
    logic [ADR_BITS-1:0]   adr;        // Line-aligned
  } lineBusCmdT;

endpackage

// File: hdl/cacheWay.sv
// One cache way with per-set tag, valid, dirty and line storage; outputs are gated for OR merging
`timescale 1ns/100ps

module cacheWay #(
  parameter  int NUM_LINES   = 8,
  localparam int SET_BITS    = $clog2(NUM_LINES),
  localparam int OFFSET_BITS = $clog2(cachePkg::LINE_LEN / 8),
  localparam int TAG_BITS    = cachePkg::ADR_BITS - SET_BITS - OFFSET_BITS
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [SET_BITS-1:0]           cacheSet,
  input  logic [TAG_BITS-1:0]           tag,              // Request tag
  input  logic [cachePkg::LINE_LEN-1:0] lineWriteData,
  input  logic [cachePkg::LINE_LEN/8-1:0] lineByteMask,
  input  logic                          victimWay,        // Fill target, only on a miss
  input  logic                          flushWay,
  input  logic                          selFlush,
  input  logic                          setValid,
  input  logic                          clearDirty,
  input  logic                          setDirty,
  input  logic                          invalidateCache,
  output logic [cachePkg::LINE_LEN-1:0] readDataLineWay,
  output logic                          hitWay,
  output logic                          validWay,
  output logic                          dirtyWay,
  output logic [TAG_BITS-1:0]           tagWay
);

  logic [TAG_BITS-1:0]           tagMem  [NUM_LINES];
  logic [cachePkg::LINE_LEN-1:0] dataMem [NUM_LINES];
  logic [NUM_LINES-1:0]          validBits;
  logic [NUM_LINES-1:0]          dirtyBits;
  logic [TAG_BITS-1:0]           storedTag;
  logic                          selData;

  assign storedTag = tagMem[cacheSet];
  assign validWay  = validBits[cacheSet];
  assign hitWay    = validWay & (storedTag == tag);

  // Flush walks ways, otherwise hit or victim owns the way
  assign selData = selFlush ? flushWay : (hitWay | victimWay);

  // AND half of the AND-OR read mux
  assign readDataLineWay = {cachePkg::LINE_LEN{selData}} & dataMem[cacheSet];
  assign tagWay          = {TAG_BITS{selData}} & storedTag;
  assign dirtyWay        = selData & dirtyBits[cacheSet];

  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (invalidateCache) begin
      validBits <= '0;        // Whole cache at once
      dirtyBits <= '0;
    end else begin
      if (selData & setValid) validBits[cacheSet] <= 1'b1;  // Fill
      if (selData & setDirty) dirtyBits[cacheSet] <= 1'b1;  // Store hit or write miss
      else if (selData & clearDirty) dirtyBits[cacheSet] <= 1'b0;
    end
  end

  // Tag and line storage
  always_ff @(posedge clk) begin
    if (selData & setValid) tagMem[cacheSet] <= tag;
    for (int b = 0; b < cachePkg::LINE_LEN / 8; b++) begin
      if (selData & lineByteMask[b]) begin
        dataMem[cacheSet][8*b +: 8] <= lineWriteData[8*b +: 8];
      end
    end
  end

endmodule

// File: hdl/cacheLru.sv
// Two-way LRU, one bit per set naming the least recently used way, and victim selection
`timescale 1ns/100ps

module cacheLru #(
  parameter  int NUM_LINES = 8,
  localparam int SET_BITS  = $clog2(NUM_LINES)
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [SET_BITS-1:0] cacheSet,
  input  logic [1:0]          hitWay,
  input  logic [1:0]          validWay,
  input  logic                lruWriteEn,      // Only asserted on a hit
  input  logic                invalidateCache,
  output logic [1:0]          victimWay        // One hot
);

  logic [NUM_LINES-1:0] lruBits;  // 1 means way 1 is LRU

  // Empty way first, then LRU way
  always_comb begin
    if (!validWay[0])     victimWay = 2'b01;
    else if (!validWay[1]) victimWay = 2'b10;
    else                   victimWay = lruBits[cacheSet] ? 2'b10 : 2'b01;
  end

  always_ff @(posedge clk) begin
    if (reset | invalidateCache) lruBits <= '0;
    else if (lruWriteEn) lruBits[cacheSet] <= hitWay[0];  // Other way becomes LRU
  end

endmodule

// File: hdl/cacheFsm.sv
// Cache control FSM; sequences hits, line fill, dirty writeback, flush walk and invalidate
`timescale 1ns/100ps

module cacheFsm (
  input  logic              clk,
  input  logic              reset,
  input  cachePkg::cacheRwE cacheRw,
  input  logic              flushCache,
  input  logic              invalidateCache,
  input  logic              cacheHit,
  input  logic              lineDirty,       // Victim or flush line is dirty
  input  logic              lineAck,
  input  logic              flushAdrFlag,    // Last set
  input  logic              flushWayFlag,    // Last way
  output logic              cacheStall,
  output logic              cacheMiss,
  output logic              cacheAccess,
  output logic [1:0]        lineRw,          // [1] fetch, [0] writeback
  output logic              selWriteback,
  output logic              selFlush,
  output logic              setValid,
  output logic              setDirty,
  output logic              clearDirty,
  output logic              lruWriteEn,
  output logic              flushAdrCntEn,
  output logic              flushWayCntEn,
  output logic              flushCntRst
);

  cachePkg::cacheStateE state, nextState;
  logic                 request;
  logic                 isWrite;
  logic                 replay;    // Hit after a fill, already counted

  assign request = cacheRw != cachePkg::RW_IDLE;
  assign isWrite = cacheRw == cachePkg::RW_WRITE;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= cachePkg::STATE_READY;
      replay <= 1'b0;
    end else begin
      state  <= nextState;
      replay <= state == cachePkg::STATE_WRITE_LINE;
    end
  end

  always_comb begin
    nextState = state;
    {cacheStall, cacheMiss, cacheAccess, selWriteback, selFlush} = '0;
    {setValid, setDirty, clearDirty, lruWriteEn} = '0;
    {flushAdrCntEn, flushWayCntEn, flushCntRst} = '0;
    lineRw = 2'b00;
    case (state)
      cachePkg::STATE_READY: begin
        flushCntRst = 1'b1;                       // Flush walk starts at set 0, way 0
        if (flushCache) begin
          cacheStall = 1'b1;
          nextState  = cachePkg::STATE_FLUSH_CHECK;
        end else if (request & invalidateCache) begin
          cacheStall = 1'b1;                      // Retry after the valid bits clear
        end else if (request & cacheHit) begin
          cacheAccess = ~replay;
          lruWriteEn  = 1'b1;
          setDirty    = isWrite;                  // Store hit
        end else if (request) begin
          {cacheStall, cacheMiss, cacheAccess} = 3'b111;
          if (lineDirty) begin
            lineRw       = 2'b01;
            selWriteback = 1'b1;
            nextState    = cachePkg::STATE_WRITEBACK;
          end else begin
            lineRw    = 2'b10;
            nextState = cachePkg::STATE_FETCH;
          end
        end
      end
      cachePkg::STATE_WRITEBACK: begin
        {cacheStall, selWriteback} = 2'b11;
        lineRw = 2'b01;
        if (lineAck) nextState = cachePkg::STATE_FETCH;
      end
      cachePkg::STATE_FETCH: begin
        cacheStall = 1'b1;
        lineRw     = 2'b10;
        if (lineAck) nextState = cachePkg::STATE_WRITE_LINE;
      end
      cachePkg::STATE_WRITE_LINE: begin
        {cacheStall, setValid} = 2'b11;
        setDirty   = isWrite;                     // Write miss merges its bytes
        clearDirty = ~isWrite;
        nextState  = cachePkg::STATE_READY;
      end
      cachePkg::STATE_FLUSH_CHECK: begin
        {cacheStall, selFlush} = 2'b11;
        if (lineDirty) begin
          lineRw    = 2'b01;
          nextState = cachePkg::STATE_FLUSH_WRITEBACK;
        end else begin
          nextState = cachePkg::STATE_FLUSH_NEXT;
        end
      end
      cachePkg::STATE_FLUSH_WRITEBACK: begin
        {cacheStall, selFlush} = 2'b11;
        lineRw = 2'b01;
        if (lineAck) begin
          clearDirty = 1'b1;
          nextState  = cachePkg::STATE_FLUSH_NEXT;
        end
      end
      cachePkg::STATE_FLUSH_NEXT: begin
        selFlush = 1'b1;
        if (flushAdrFlag & flushWayFlag) begin
          nextState = cachePkg::STATE_READY;      // Stall drops here, flush done
        end else begin
          cacheStall    = 1'b1;
          flushWayCntEn = 1'b1;
          flushAdrCntEn = flushWayFlag;           // Next set after last way
          nextState     = cachePkg::STATE_FLUSH_CHECK;
        end
      end
      default: nextState = cachePkg::STATE_READY;
    endcase
  end

endmodule

// File: hdl/cache.sv
// Cache datapath; joins ways, LRU and FSM with set muxing, word select, store merge and flush walk
`timescale 1ns/100ps

module cache #(
  parameter int NUM_WAYS  = 2,
  parameter int NUM_LINES = 8
) (
  input  logic                          clk,
  input  logic                          reset,
  input  cachePkg::cpuReqT              cpuReq,
  input  logic                          flushCache,
  input  logic                          invalidateCache,
  input  logic                          lineAck,
  input  logic                          selBusBeat,     // Writeback beat picks the word
  input  logic [cachePkg::LOG_BPL-1:0]  beatCount,
  input  logic [cachePkg::LINE_LEN-1:0] fetchBuffer,
  output logic                          cacheStall,
  output logic [cachePkg::WORD_LEN-1:0] readDataWord,
  output logic                          cacheMiss,
  output logic                          cacheAccess,
  output cachePkg::lineBusCmdT          lineCmd
);

  localparam int OFFSET_BITS = $clog2(cachePkg::LINE_LEN / 8);
  localparam int SET_BITS    = $clog2(NUM_LINES);
  localparam int TAG_BITS    = cachePkg::ADR_BITS - SET_BITS - OFFSET_BITS;
  localparam int LINE_BYTES  = cachePkg::LINE_LEN / 8;
  localparam int WORD_BYTES  = cachePkg::WORD_LEN / 8;

  logic [cachePkg::LINE_LEN-1:0] readDataLineWay [NUM_WAYS];
  logic [TAG_BITS-1:0]           tagWay [NUM_WAYS];
  logic [NUM_WAYS-1:0]           hitWay, validWay, dirtyWay, victimWay, fillWay;
  logic [cachePkg::LINE_LEN-1:0] readDataLine, lineWriteData;
  logic [TAG_BITS-1:0]           tagSel;
  logic [SET_BITS-1:0]           reqSet, cacheSet, flushAdr;
  logic [NUM_WAYS-1:0]           flushWay;
  logic [cachePkg::LOG_BPL-1:0]  wordOffset;
  logic [LINE_BYTES-1:0]         storeMask, mergeMask, lineByteMask;
  logic [1:0]                    lineRw;
  logic                          cacheHit, lineDirty, selWriteback, selFlush;
  logic                          setValid, setDirty, clearDirty, lruWriteEn;
  logic                          flushAdrCntEn, flushWayCntEn, flushCntRst;
  logic                          flushAdrFlag, flushWayFlag;

  //////////////////////////////
  // Read path
  assign reqSet   = cpuReq.adr[OFFSET_BITS +: SET_BITS];
  assign cacheSet = selFlush ? flushAdr : reqSet;     // Flush walk owns the index
  assign fillWay  = victimWay & {NUM_WAYS{~cacheHit}}; // Victim only matters on a miss

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gWay
    cacheWay #(.NUM_LINES(NUM_LINES)) wayInst (
      .clk, .reset, .cacheSet, .tag(cpuReq.adr[cachePkg::ADR_BITS-1 -: TAG_BITS]),
      .lineWriteData, .lineByteMask, .victimWay(fillWay[w]), .flushWay(flushWay[w]),
      .selFlush, .setValid, .clearDirty, .setDirty, .invalidateCache,
      .readDataLineWay(readDataLineWay[w]), .hitWay(hitWay[w]), .validWay(validWay[w]),
      .dirtyWay(dirtyWay[w]), .tagWay(tagWay[w]));
  end

  cacheLru #(.NUM_LINES(NUM_LINES)) lruInst (
    .clk, .reset, .cacheSet, .hitWay, .validWay, .lruWriteEn, .invalidateCache, .victimWay);

  assign cacheHit  = |hitWay;
  assign lineDirty = |dirtyWay;

  // OR half of the AND-OR mux
  always_comb begin
    readDataLine = '0;
    tagSel       = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      readDataLine |= readDataLineWay[w];
      tagSel       |= tagWay[w];
    end
  end

  assign wordOffset   = selBusBeat ? beatCount : cpuReq.adr[OFFSET_BITS-1 -: cachePkg::LOG_BPL];
  assign readDataWord = readDataLine[wordOffset*cachePkg::WORD_LEN +: cachePkg::WORD_LEN];

  // Line address for fetch, victim writeback or flush writeback
  always_comb begin
    if (selFlush)          lineCmd.adr = {tagSel, flushAdr, {OFFSET_BITS{1'b0}}};
    else if (selWriteback) lineCmd.adr = {tagSel, reqSet, {OFFSET_BITS{1'b0}}};
    else                   lineCmd.adr = {cpuReq.adr[cachePkg::ADR_BITS-1:OFFSET_BITS],
                                          {OFFSET_BITS{1'b0}}};
    lineCmd.rw = lineRw;
  end

  //////////////////////////////
  // Write path
  assign storeMask    = LINE_BYTES'(cpuReq.byteMask) << (WORD_BYTES * wordOffset);
  assign mergeMask    = (setValid & ~setDirty) ? '0 : storeMask;  // Read fill keeps whole line
  assign lineByteMask = setValid ? '1 : (setDirty ? storeMask : '0);

  // Store bytes over the fetched line
  always_comb begin
    for (int b = 0; b < LINE_BYTES; b++) begin
      lineWriteData[8*b +: 8] = mergeMask[b] ? cpuReq.writeData[8*(b % WORD_BYTES) +: 8]
                                             : fetchBuffer[8*b +: 8];
    end
  end

  //////////////////////////////
  // Flush walk
  always_ff @(posedge clk) begin
    if (reset | flushCntRst) begin
      flushAdr <= '0;
      flushWay <= NUM_WAYS'(1);        // One-hot way pointer starts at way 0
    end else begin
      if (flushAdrCntEn) flushAdr <= flushAdr + 1'b1;
      if (flushWayCntEn) flushWay <= {flushWay[NUM_WAYS-2:0], flushWay[NUM_WAYS-1]};
    end
  end

  assign flushAdrFlag = flushAdr == SET_BITS'(NUM_LINES - 1);
  assign flushWayFlag = flushWay[NUM_WAYS-1];

  cacheFsm fsmInst (
    .clk, .reset, .cacheRw(cpuReq.rw), .flushCache, .invalidateCache, .cacheHit, .lineDirty,
    .lineAck, .flushAdrFlag, .flushWayFlag, .cacheStall, .cacheMiss, .cacheAccess, .lineRw,
    .selWriteback, .selFlush, .setValid, .setDirty, .clearDirty, .lruWriteEn,
    .flushAdrCntEn, .flushWayCntEn, .flushCntRst);

endmodule

// File: hdl/lineBusInterface.sv
// Line bus engine; runs four word beats per line command and collects fetched words
`timescale 1ns/100ps

module lineBusInterface (
  input  logic                          clk,
  input  logic                          reset,
  input  cachePkg::lineBusCmdT          lineCmd,       // Held until lineAck
  input  logic [cachePkg::WORD_LEN-1:0] readDataWord,  // Writeback word from the cache
  input  logic                          busAck,
  input  logic [cachePkg::WORD_LEN-1:0] busReadData,
  output cachePkg::busReqT              busReq,
  output logic [cachePkg::LOG_BPL-1:0]  beatCount,
  output logic                          selBusBeat,
  output logic [cachePkg::LINE_LEN-1:0] fetchBuffer,
  output logic                          lineAck
);

  logic busy;       // Line command in progress
  logic lastBeat;

  assign lastBeat = beatCount == cachePkg::LOG_BPL'(cachePkg::BEATS_PER_LINE - 1);
  assign lineAck  = busy & busAck & lastBeat;         // Cache leaves its state on this
  assign selBusBeat = busy & lineCmd.rw[0];

  always_comb begin
    busReq.read      = busy & lineCmd.rw[1];
    busReq.write     = busy & lineCmd.rw[0];
    busReq.adr       = lineCmd.adr | (cachePkg::ADR_BITS'(beatCount) << 2);  // Line + 4*beat
    busReq.writeData = readDataWord;
  end

  // Beat sequencing, starts one cycle after the command appears
  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      beatCount <= '0;
    end else if (!busy) begin
      busy      <= |lineCmd.rw;
      beatCount <= '0;
    end else if (busAck) begin
      beatCount <= beatCount + 1'b1;  // Wraps to 0 after the last beat
      busy      <= ~lastBeat;
    end
  end

  // Fetched word lands at its beat position
  always_ff @(posedge clk) begin
    if (busReq.read & busAck) begin
      fetchBuffer[beatCount*cachePkg::WORD_LEN +: cachePkg::WORD_LEN] <= busReadData;
    end
  end

endmodule

// File: hdl/cacheSubsystem.sv
// Top level of the data cache subsystem; joins the cache and the line bus engine
`timescale 1ns/100ps

module cacheSubsystem #(
  parameter int NUM_WAYS  = 2,
  parameter int NUM_LINES = 8
) (
  input  logic                          clk,
  input  logic                          reset,
  input  cachePkg::cpuReqT              cpuReq,
  input  logic                          flushCache,
  input  logic                          invalidateCache,
  input  logic                          busAck,
  input  logic [cachePkg::WORD_LEN-1:0] busReadData,
  output logic                          cacheStall,
  output logic [cachePkg::WORD_LEN-1:0] readDataWord,
  output logic                          cacheMiss,
  output logic                          cacheAccess,
  output cachePkg::busReqT              busReq
);

  cachePkg::lineBusCmdT          lineCmd;
  logic                          lineAck, selBusBeat;
  logic [cachePkg::LOG_BPL-1:0]  beatCount;
  logic [cachePkg::LINE_LEN-1:0] fetchBuffer;

  cache #(.NUM_WAYS(NUM_WAYS), .NUM_LINES(NUM_LINES)) cacheInst (
    .clk, .reset, .cpuReq, .flushCache, .invalidateCache, .lineAck, .selBusBeat, .beatCount,
    .fetchBuffer, .cacheStall, .readDataWord, .cacheMiss, .cacheAccess, .lineCmd);

  lineBusInterface busInst (
    .clk, .reset, .lineCmd, .readDataWord, .busAck, .busReadData, .busReq, .beatCount,
    .selBusBeat, .fetchBuffer, .lineAck);

endmodule

// File: sim/cacheSubsystem_properties.sv
// Concurrent checks on the bus beat and stall protocol, bound into the cache subsystem top level
`timescale 1ns/100ps

module cacheSubsystemProperties (
  input logic             clk,
  input logic             reset,
  input cachePkg::busReqT busReq,
  input logic             busAck,
  input logic             cacheStall,
  input logic             cacheMiss,
  input logic             cacheAccess
);

  // One direction per beat
  busOneDir: assert property (@(posedge clk) disable iff (reset)
    !(busReq.read && busReq.write))
    else $error("busReq has read and write high together");

  // Beat held until acknowledged
  busHold: assert property (@(posedge clk) disable iff (reset)
    (busReq.read || busReq.write) && !busAck |=> $stable({busReq.read, busReq.write, busReq.adr}))
    else $error("busReq changed before busAck");

  busWriteHold: assert property (@(posedge clk) disable iff (reset)
    busReq.write && !busAck |=> $stable(busReq.writeData))
    else $error("busReq write data changed before busAck");

  missIsAccess: assert property (@(posedge clk) disable iff (reset) cacheMiss |-> cacheAccess)
    else $error("cacheMiss without cacheAccess");

  stallAfterReset: assert property (@(posedge clk) reset |=> !cacheStall)
    else $error("cacheStall high right after reset");

endmodule

bind cacheSubsystem cacheSubsystemProperties propsInst (
  .clk, .reset, .busReq, .busAck, .cacheStall, .cacheMiss, .cacheAccess);

// File: sim/cacheSubsystemTb.sv
// Cache subsystem testbench; replays the vector file against memory and reference models
`timescale 1ns/100ps

module cacheSubsystemTb;

  localparam int PERIOD      = 100;
  localparam int STALL_LIMIT = 1000;  // Cycles allowed for a full flush with slow acks
  localparam int MAX_VEC     = 64;

  // One vector line
  typedef struct packed {
    logic [3:0]  op;     // 0 read, 1 write, 2 flush, 3 invalidate, 4 writeback check, f end
    logic [15:0] adr;
    logic [3:0]  mask;
    logic [31:0] data;
    logic [3:0]  miss;   // Expected miss flag in bit 0
  } vectorT;

  logic                          clk = 1'b0;
  logic                          reset;
  cachePkg::cpuReqT              cpuReq;
  logic                          flushCache, invalidateCache, busAck;
  logic [cachePkg::WORD_LEN-1:0] busReadData, readDataWord;
  logic                          cacheStall, cacheMiss, cacheAccess;
  cachePkg::busReqT              busReq;

  logic [31:0]      mem [4096];       // Memory behind the bus
  logic [31:0]      refMem [4096];    // Reference model, updated by every store
  logic [59:0]      vecMem [MAX_VEC];
  cachePkg::busReqT writeLog [$];     // Bus write beats of the last operation
  int               storedIdx [$];    // Words touched by stores
  logic [31:0]      randState = 32'h20d0_3431;
  int               ackDelay = -1;    // Cycles left before busAck, -1 when idle
  int               errorCount = 0;
  int               timeoutCount = 0;

  cacheSubsystem #(.NUM_WAYS(2), .NUM_LINES(8)) cacheSubsystem_i (.*);

  always #(PERIOD/2) clk = ~clk;

  //////////////////////////////
  // Helpers
  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = randState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    randState = x;
    return x;
  endfunction

  // Byte address in the upper half and its inverse below
  function automatic logic [31:0] fillWord(input int idx);
    logic [15:0] a;
    a = 16'(idx * 4);
    return {a, ~a};
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] mask);
    logic [31:0] merged;
    merged = old;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) merged[8*b +: 8] = data[8*b +: 8];
    end
    return merged;
  endfunction

  task automatic checkWord(input string name, input logic [cachePkg::WORD_LEN-1:0] expected,
                           input logic [cachePkg::WORD_LEN-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkMiss(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error %s miss: expected %b, actual %b", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkBusReq(input string name, input cachePkg::busReqT expected,
                             input cachePkg::busReqT actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  // Samples in the low phase where DUT outputs are settled
  task automatic waitStallLow(output bit timedOut);
    int cycles;
    cycles = 0;
    while (cacheStall === 1'b1 && cycles < STALL_LIMIT) begin
      @(negedge clk);
      #(PERIOD/4);
      cycles++;
    end
    timedOut = cacheStall !== 1'b0;
  endtask

  //////////////////////////////
  // Memory model answering one beat per busAck pulse
  always @(negedge clk) begin
    if (reset || busAck) begin
      busAck   = 1'b0;                           // Pulse lasts one cycle
      ackDelay = -1;
    end else if (busReq.read || busReq.write) begin
      if (ackDelay < 0) ackDelay = int'(nextRandom() % 4);  // 0 to 3 wait cycles
      if (ackDelay == 0) begin
        busAck = 1'b1;
        if (busReq.read) busReadData = mem[busReq.adr[13:2]];
        else begin
          mem[busReq.adr[13:2]] = busReq.writeData;
          writeLog.push_back(busReq);
        end
        ackDelay = -1;
      end else ackDelay--;
    end
  end

  //////////////////////////////
  // Vector replay
  initial begin
    vectorT           vec;
    cachePkg::busReqT expBeat;
    string            name;
    int               n;
    int               idx;
    bit               timedOut;
    reset           = 1'b1;
    cpuReq          = '0;
    flushCache      = 1'b0;
    invalidateCache = 1'b0;
    busAck          = 1'b0;
    busReadData     = '0;
    for (int i = 0; i < 4096; i++) begin
      mem[i]    = fillWord(i);
      refMem[i] = mem[i];
    end
    $readmemh("sim/cacheVectors.txt", vecMem);
    repeat (8) @(negedge clk);
    reset    = 1'b0;
    n        = 0;
    timedOut = 1'b0;
    while (!timedOut && n < MAX_VEC && !$isunknown(vecMem[n]) && vecMem[n][59:56] != 4'hf) begin
      vec  = vecMem[n];
      name = $sformatf("vector %0d op %0d adr %h", n, vec.op, vec.adr);
      idx  = vec.adr[13:2];
      case (vec.op)
        4'h0, 4'h1: begin
          writeLog.delete();
          @(negedge clk);
          cpuReq.rw        = (vec.op == 4'h1) ? cachePkg::RW_WRITE : cachePkg::RW_READ;
          cpuReq.adr       = vec.adr;
          cpuReq.byteMask  = vec.mask;
          cpuReq.writeData = vec.data;
          #(PERIOD/4);
          checkMiss(name, vec.miss[0], cacheMiss);  // Pulse only in the first cycle
          if (cacheAccess !== 1'b1) begin
            $display("** Error %s access: expected 1, actual %b", name, cacheAccess);
            errorCount++;
          end
          waitStallLow(timedOut);
          if (!timedOut && vec.op == 4'h0) checkWord(name, refMem[idx], readDataWord);
          if (!timedOut && vec.op == 4'h1) begin
            refMem[idx] = mergeBytes(refMem[idx], vec.data, vec.mask);
            storedIdx.push_back(idx);
          end
        end
        4'h2: begin
          writeLog.delete();
          @(negedge clk);
          cpuReq.rw  = cachePkg::RW_IDLE;
          flushCache = 1'b1;                      // Held until stall falls
          #(PERIOD/4);
          waitStallLow(timedOut);
          @(negedge clk);
          flushCache = 1'b0;
          if (!timedOut) begin
            foreach (storedIdx[i]) checkWord(name, refMem[storedIdx[i]], mem[storedIdx[i]]);
          end
        end
        4'h3: begin
          @(negedge clk);
          cpuReq.rw       = cachePkg::RW_IDLE;
          invalidateCache = 1'b1;                 // One-cycle pulse
          @(negedge clk);
          invalidateCache = 1'b0;
        end
        4'h4: begin
          if (writeLog.size() != 4) begin
            $display("Error: %s expected 4 writeback beats but saw %0d", name, writeLog.size());
            errorCount++;
          end else begin
            for (int i = 0; i < 4; i++) begin
              expBeat.read      = 1'b0;
              expBeat.write     = 1'b1;
              expBeat.adr       = vec.adr + 16'(4 * i);  // Line base plus beat offset
              expBeat.writeData = refMem[idx + i];
              checkBusReq($sformatf("%s beat %0d", name, i), expBeat, writeLog[i]);
            end
          end
        end
        default: begin
          $display("Error: %s has an unknown operation code", name);
          errorCount++;
        end
      endcase
      n++;
    end
    if (timedOut) begin
      $display("Timeout: cacheStall stayed high for %0d cycles in %s", STALL_LIMIT, name);
      timeoutCount++;
    end
    $display("Errors: %0d value mismatches, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: sim/cacheVectors.txt
// Columns are op, address, byte mask, data and expected miss flag, all hex
// Ops are 0 read, 1 write, 2 flush, 3 invalidate, 4 writeback check of a line, f end
0_0010_0_00000000_1  // First read of a line misses
0_0018_0_00000000_0  // Same line hits
0_001c_0_00000000_0
1_0014_3_a5a51234_0  // Masked store to a resident line
0_0014_0_00000000_0
0_0100_0_00000000_1  // Line A, set 0
0_0200_0_00000000_1  // Line B, set 0
0_0104_0_00000000_0  // A again, B becomes LRU
0_0300_0_00000000_1  // Line C evicts B
0_0108_0_00000000_0  // A still resident
0_0204_0_00000000_1  // B misses again
0_0024_0_00000000_1  // Set 2 line
1_0024_f_deadbeef_0  // Makes it dirty
0_0120_0_00000000_1
0_0220_0_00000000_1  // Evicts the dirty line
4_0020_0_00000000_0  // Four write beats of line 0x0020
0_0024_0_00000000_1  // Re-read brings the stored word back
1_0030_f_11112222_1  // Write miss
1_0044_c_33334444_1  // Write miss, upper half
1_0038_1_00000055_0  // Store hit
2_0000_0_00000000_0  // Flush all dirty lines
3_0000_0_00000000_0  // Invalidate all
0_0014_0_00000000_1
0_0100_0_00000000_1
0_0044_0_00000000_1
0_0038_0_00000000_1
f_0000_0_00000000_0

// File: build.f
hdl/cachePkg.sv
hdl/cacheWay.sv
hdl/cacheLru.sv
hdl/cacheFsm.sv
hdl/cache.sv
hdl/lineBusInterface.sv
hdl/cacheSubsystem.sv
sim/cacheSubsystem_properties.sv
sim/cacheSubsystemTb.sv

// File: Bender.yml
package:
  name: cache_subsystem

sources:
  # RTL in compile order
  - files:
      - hdl/cachePkg.sv
      - hdl/cacheWay.sv
      - hdl/cacheLru.sv
      - hdl/cacheFsm.sv
      - hdl/cache.sv
      - hdl/lineBusInterface.sv
      - hdl/cacheSubsystem.sv
  # Bound properties and testbench
  - target: simulation
    files:
      - sim/cacheSubsystem_properties.sv
      - sim/cacheSubsystemTb.sv
